/* alu_core.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_op_if.sv
hw/alu_decoder.sv
hw/alu_execute.sv
hw/alu_writeback.sv
hw/alu_core.sv
tb/alu_core_assertions.sv
tb/alu_core_tb.sv

/* hw/alu_core.sv */
// ======================================
// ALU top level. One enable per instruction,
// rz and ccr valid one cycle later
// ======================================
`include "alu_params.svh"
`default_nettype none

module alu_core import alu_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [1:0]             format,      // 0 a, 1 b, 2 c
	input  logic [`ALU_DATA_W-1:0] instruction,
	input  logic [`ALU_DATA_W-1:0] ra,
	input  logic [`ALU_DATA_W-1:0] rb,
	output logic [`ALU_DATA_W-1:0] rz,
	output logic [`ALU_DATA_W-1:0] ccr,
	output logic                   result_valid
);

	logic carry_flag;

	alu_op_if     op_bus ();
	alu_result_if res_bus ();

	alu_decoder i_decoder (
		.enable      (enable),
		.format      (alu_format_e'(format)),
		.instruction (alu_instr_u'(instruction)),
		.ra          (ra),
		.rb          (rb),
		.op_bus      (op_bus)
	);

	alu_execute i_execute (
		.op_bus   (op_bus),
		.carry_in (carry_flag),
		.res_bus  (res_bus)
	);

	alu_writeback i_writeback (
		.clock        (clock),
		.rst_n        (rst_n),
		.res_bus      (res_bus),
		.carry_flag   (carry_flag),
		.rz           (rz),
		.ccr          (ccr),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

/* hw/alu_decoder.sv */
// ======================================
// Instruction decoder, combinational.
// Picks the format layout, maps the opcode
// to an operation, or to a fault load
// ======================================
`include "alu_params.svh"
`default_nettype none

module alu_decoder import alu_pkg::*; (
	input  logic                   enable,
	input  alu_format_e            format,
	input  alu_instr_u             instruction,
	input  logic [`ALU_DATA_W-1:0] ra,
	input  logic [`ALU_DATA_W-1:0] rb,
	alu_op_if.source               op_bus
);

	localparam int EXT_W = `ALU_DATA_W - `ALU_IMM_C_W; // Extension bits for LD#, LDU#

	logic [`ALU_DATA_W-1:0] imm_sext;
	logic [`ALU_DATA_W-1:0] imm_zext;

	assign imm_sext = {{EXT_W{instruction.fmt_c.imm[`ALU_IMM_C_W-1]}}, instruction.fmt_c.imm};
	assign imm_zext = {{EXT_W{1'b0}}, instruction.fmt_c.imm};

	always_comb begin
		op_bus.valid     = enable;
		op_bus.op        = OP_NOP;
		op_bus.operand_a = ra;
		op_bus.operand_b = rb;
		op_bus.fault     = FAULT_NONE;
		case (format)
			FMT_A: begin
				case (instruction.fmt_a.opcode)
					`ALU_OPC_ADD:  op_bus.op = OP_ADD;
					`ALU_OPC_SUB:  op_bus.op = OP_SUB;
					`ALU_OPC_AND:  op_bus.op = OP_AND;
					`ALU_OPC_OR:   op_bus.op = OP_OR;
					`ALU_OPC_NEG:  op_bus.op = OP_NEG;
					`ALU_OPC_XOR:  op_bus.op = OP_XOR;
					`ALU_OPC_COMP: op_bus.op = OP_COMP;
					`ALU_OPC_LSR:  op_bus.op = OP_LSR;
					`ALU_OPC_ASR:  op_bus.op = OP_ASR;
					`ALU_OPC_LSL:  op_bus.op = OP_LSL;
					`ALU_OPC_ROR:  op_bus.op = OP_ROR;
					`ALU_OPC_ROL:  op_bus.op = OP_ROL;
					`ALU_OPC_MOVE: op_bus.op = OP_MOVE;
					default: begin // Includes LBI and LDRI
						op_bus.op        = OP_LOAD;
						op_bus.operand_a = `ALU_ERR_FMT_A;
						op_bus.fault     = FAULT_INR;
					end
				endcase
			end
			FMT_B: begin
				// NOP is the only format b instruction left
				if (instruction.fmt_b.opcode != `ALU_OPC_NOP) begin
					op_bus.op        = OP_LOAD;
					op_bus.operand_a = `ALU_ERR_FMT_B;
					op_bus.fault     = FAULT_INR;
				end
			end
			FMT_C: begin
				case (instruction.fmt_c.opcode)
					`ALU_OPC_NOP: op_bus.op = OP_NOP;
					`ALU_OPC_LDI: begin
						op_bus.op        = OP_LOAD;
						op_bus.operand_a = imm_sext;
					end
					`ALU_OPC_LDUI: begin
						op_bus.op        = OP_LOAD;
						op_bus.operand_a = imm_zext;
					end
					default: begin
						op_bus.op        = OP_LOAD;
						op_bus.operand_a = `ALU_ERR_FMT_C;
						op_bus.fault     = FAULT_INR;
					end
				endcase
			end
			default: begin // Format 3 does not exist
				op_bus.op        = OP_LOAD;
				op_bus.operand_a = `ALU_ERR_FORMAT;
				op_bus.fault     = FAULT_IFNR;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/alu_execute.sv */
// ======================================
// Execute stage, combinational. Result,
// shifted-out carry and signed overflow
// of one decoded operation
// ======================================
`include "alu_params.svh"
`default_nettype none

module alu_execute import alu_pkg::*; (
	alu_op_if.sink       op_bus,
	input  logic         carry_in, // Current C flag, fills rotates
	alu_result_if.source res_bus
);

	localparam int MSB = `ALU_DATA_W - 1;

	logic [`ALU_DATA_W-1:0] a;
	logic [`ALU_DATA_W-1:0] b;
	logic [`ALU_DATA_W-1:0] result;
	logic                   carry;
	logic                   carry_write;
	logic                   overflow;

	assign a = op_bus.operand_a;
	assign b = op_bus.operand_b;

	always_comb begin
		result      = '0;
		carry       = carry_in;
		carry_write = 1'b0;
		overflow    = 1'b0; // Cleared by all but ADD and SUB
		case (op_bus.op)
			OP_ADD: begin
				result   = a + b; // Wraps
				overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
			end
			OP_SUB: begin
				result   = a - b;
				overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
			end
			OP_AND:  result = a & b;
			OP_OR:   result = a | b;
			OP_NEG:  result = -a; // Two's complement
			OP_XOR:  result = a ^ b;
			OP_COMP: result = ~a; // One's complement
			OP_LSR: begin
				result      = a >> 1;
				carry       = a[0];
				carry_write = 1'b1;
			end
			OP_ASR: begin
				result      = $signed(a) >>> 1; // Sign fills bit 31
				carry       = a[0];
				carry_write = 1'b1;
			end
			OP_LSL: begin
				result      = a << 1;
				carry       = a[MSB];
				carry_write = 1'b1;
			end
			OP_ROR: begin
				result      = {carry_in, a[MSB:1]}; // Rotate through C
				carry       = a[0];
				carry_write = 1'b1;
			end
			OP_ROL: begin
				result      = {a[MSB-1:0], carry_in};
				carry       = a[MSB];
				carry_write = 1'b1;
			end
			OP_MOVE, OP_LOAD: result = a;
			default: result = '0; // NOP, nothing written
		endcase
	end

	assign res_bus.valid       = op_bus.valid;
	assign res_bus.hold        = (op_bus.op == OP_NOP);
	assign res_bus.result      = result;
	assign res_bus.carry       = carry;
	assign res_bus.carry_write = carry_write;
	assign res_bus.overflow    = overflow;
	assign res_bus.fault       = op_bus.fault;

endmodule

`default_nettype wire

/* hw/alu_op_if.sv */
// ======================================
// Decoder to execute and execute to
// writeback buses, valid strobe only
// ======================================
`include "alu_params.svh"
`default_nettype none

interface alu_op_if import alu_pkg::*; ();
	logic                   valid;     // One cycle per enabled instruction
	alu_op_e                op;
	logic [`ALU_DATA_W-1:0] operand_a; // Error pattern on a fault
	logic [`ALU_DATA_W-1:0] operand_b;
	alu_fault_e             fault;

	modport source (output valid, op, operand_a, operand_b, fault);
	modport sink   (input  valid, op, operand_a, operand_b, fault);
endinterface

interface alu_result_if import alu_pkg::*; ();
	logic                   valid;
	logic                   hold;        // NOP, keep rz and ccr
	logic [`ALU_DATA_W-1:0] result;
	logic                   carry;
	logic                   carry_write; // Shifts and rotates only
	logic                   overflow;
	alu_fault_e             fault;

	modport source (output valid, hold, result, carry, carry_write, overflow, fault);
	modport sink   (input  valid, hold, result, carry, carry_write, overflow, fault);
endinterface

`default_nettype wire

/* hw/alu_params.svh */
// ======================================
// Widths, opcode values and error patterns
// of the ALU, shared by package and RTL.
// Include before `default_nettype none
// ======================================
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_W   32 // Data word
`define ALU_REG_W    5  // Register field of formats a and b
`define ALU_OPC_A_W  17 // Format a opcode
`define ALU_OPC_W    6  // Format b and c opcode
`define ALU_IMM_B_W  16 // Format b immediate, bits 21:6
`define ALU_IMM_C_W  26 // Format c immediate, bits 31:6
`define ALU_FLAG_W   6  // Live ccr bits

// Format a opcodes, function code sits in bits 12:6
`define ALU_OPC_ADD  17'h0_0040
`define ALU_OPC_SUB  17'h0_0100
`define ALU_OPC_AND  17'h0_0200
`define ALU_OPC_OR   17'h0_0240
`define ALU_OPC_NEG  17'h0_0280
`define ALU_OPC_XOR  17'h0_02C0
`define ALU_OPC_COMP 17'h0_0300
`define ALU_OPC_LSR  17'h0_0400
`define ALU_OPC_ASR  17'h0_0440
`define ALU_OPC_LSL  17'h0_04C0
`define ALU_OPC_ROR  17'h0_0640
`define ALU_OPC_ROL  17'h0_0680
`define ALU_OPC_MOVE 17'h0_0800

// Format b and c opcodes
`define ALU_OPC_NOP  6'b11_1111
`define ALU_OPC_LDI  6'b10_0010 // LD#, sign extended
`define ALU_OPC_LDUI 6'b10_0011 // LDU#, zero extended

// Results of rejected instructions
`define ALU_ERR_FMT_A  32'hFFFF_FFFF
`define ALU_ERR_FMT_B  32'hFFFF_FFFE
`define ALU_ERR_FMT_C  32'hFFFF_FFFD
`define ALU_ERR_FORMAT 32'hF0F0_F0F0

`endif

/* hw/alu_pkg.sv */
// ======================================
// ALU types: instruction word layouts,
// internal operations, faults, ccr bits
// ======================================
`include "alu_params.svh"
`default_nettype none

package alu_pkg;

	// Format a: two sources, destination, long opcode
	typedef struct packed {
		logic [`ALU_REG_W-1:0]   rsrc1;
		logic [`ALU_REG_W-1:0]   rsrc2;
		logic [`ALU_REG_W-1:0]   rdst;
		logic [`ALU_OPC_A_W-1:0] opcode;
	} alu_fmt_a_t;

	// Format b: two sources, immediate operand, short opcode
	typedef struct packed {
		logic [`ALU_REG_W-1:0]   rsrc1;
		logic [`ALU_REG_W-1:0]   rsrc2;
		logic [`ALU_IMM_B_W-1:0] imm;   // Only NOP is kept, field not used
		logic [`ALU_OPC_W-1:0]   opcode;
	} alu_fmt_b_t;

	// Format c: long immediate, short opcode
	typedef struct packed {
		logic [`ALU_IMM_C_W-1:0] imm;
		logic [`ALU_OPC_W-1:0]   opcode;
	} alu_fmt_c_t;

	// Same 32 bits, read per format
	typedef union packed {
		alu_fmt_a_t fmt_a;
		alu_fmt_b_t fmt_b;
		alu_fmt_c_t fmt_c;
	} alu_instr_u;

	typedef enum logic [1:0] {FMT_A, FMT_B, FMT_C, FMT_BAD} alu_format_e;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NEG, OP_XOR, OP_COMP,
		OP_LSR, OP_ASR, OP_LSL, OP_ROR, OP_ROL,
		OP_MOVE,
		OP_LOAD, // Result is operand a
		OP_NOP
	} alu_op_e;

	typedef enum logic [1:0] {FAULT_NONE, FAULT_INR, FAULT_IFNR} alu_fault_e;

	// ccr bit positions
	localparam int CCR_C    = 0;
	localparam int CCR_N    = 1;
	localparam int CCR_V    = 2;
	localparam int CCR_Z    = 3;
	localparam int CCR_INR  = 4;
	localparam int CCR_IFNR = 5;

endpackage

`default_nettype wire

/* hw/alu_writeback.sv */
// ======================================
// Writeback registers: rz, the six ccr
// flags and the result_valid pulse
// ======================================
`include "alu_params.svh"
`default_nettype none

module alu_writeback import alu_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	alu_result_if.sink             res_bus,
	output logic                   carry_flag, // Back to execute for rotates
	output logic [`ALU_DATA_W-1:0] rz,
	output logic [`ALU_DATA_W-1:0] ccr,
	output logic                   result_valid
);

	logic [`ALU_FLAG_W-1:0] flags;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rz           <= '0;
			flags        <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= res_bus.valid; // NOP pulses too
			if (res_bus.valid && !res_bus.hold) begin
				rz                <= res_bus.result;
				flags[CCR_Z]      <= (res_bus.result == '0);
				flags[CCR_N]      <= res_bus.result[`ALU_DATA_W-1];
				flags[CCR_V]      <= res_bus.overflow;
				flags[CCR_INR]    <= (res_bus.fault == FAULT_INR);
				flags[CCR_IFNR]   <= (res_bus.fault == FAULT_IFNR);
				if (res_bus.carry_write) begin
					flags[CCR_C] <= res_bus.carry; // C held unless shifted
				end
			end
		end
	end

	assign carry_flag = flags[CCR_C];
	assign ccr        = {{(`ALU_DATA_W - `ALU_FLAG_W){1'b0}}, flags}; // Upper bits spare

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module alu_core_tb -f alu_core.f -o alu_core_sim
./obj_dir/alu_core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -qx "All checks passed" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* tb/alu_core_assertions.sv */
// ========================================
// Bound checker for the ALU. Shadow rz and
// ccr follow the instruction rules, and
// assertions compare them a cycle later
// ========================================
`include "alu_params.svh"
`default_nettype none

module alu_core_assertions import alu_pkg::*; (
	input logic                   clock,
	input logic                   rst_n,
	input logic                   enable,
	input logic [1:0]             format,
	input logic [`ALU_DATA_W-1:0] instruction,
	input logic [`ALU_DATA_W-1:0] ra,
	input logic [`ALU_DATA_W-1:0] rb,
	input logic [`ALU_DATA_W-1:0] rz,
	input logic [`ALU_DATA_W-1:0] ccr,
	input logic                   result_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MSB = `ALU_DATA_W - 1;

	logic [`ALU_DATA_W-1:0] exp_rz;
	logic [`ALU_FLAG_W-1:0] exp_flags;
	logic                   exp_valid;      // Enable seen at the last edge
	logic [`ALU_DATA_W-1:0] nxt_rz;
	logic [`ALU_FLAG_W-1:0] nxt_flags;
	logic                   nxt_hold;       // NOP keeps everything
	logic [`ALU_DATA_W-1:0] exp_ccr;
	int rz_errors      = 0;
	int ccr_errors     = 0;
	int valid_errors   = 0;
	int reset_errors   = 0;

	// Expected outcome of the instruction on the inputs now
	always_comb begin
		logic [`ALU_OPC_A_W-1:0] opc_a;
		logic [`ALU_OPC_W-1:0]   opc;
		logic [`ALU_IMM_C_W-1:0] imm;
		logic [`ALU_DATA_W:0]    wide; // Guard bit for signed overflow
		opc_a     = instruction[`ALU_OPC_A_W-1:0];
		opc       = instruction[`ALU_OPC_W-1:0];
		imm       = instruction[MSB:`ALU_OPC_W];
		wide      = '0;
		nxt_hold  = 1'b0;
		nxt_rz    = '0;
		nxt_flags = '0;
		nxt_flags[CCR_C] = exp_flags[CCR_C]; // Kept unless shifted
		case (format)
			2'd0: begin
				case (opc_a)
					`ALU_OPC_ADD: begin
						wide   = {ra[MSB], ra} + {rb[MSB], rb};
						nxt_rz = wide[MSB:0];
						nxt_flags[CCR_V] = wide[MSB+1] ^ wide[MSB];
					end
					`ALU_OPC_SUB: begin
						wide   = {ra[MSB], ra} - {rb[MSB], rb};
						nxt_rz = wide[MSB:0];
						nxt_flags[CCR_V] = wide[MSB+1] ^ wide[MSB];
					end
					`ALU_OPC_AND:  nxt_rz = ra & rb;
					`ALU_OPC_OR:   nxt_rz = ra | rb;
					`ALU_OPC_NEG:  nxt_rz = 32'd0 - ra;
					`ALU_OPC_XOR:  nxt_rz = ra ^ rb;
					`ALU_OPC_COMP: nxt_rz = ra ^ {`ALU_DATA_W{1'b1}};
					`ALU_OPC_LSR: begin
						nxt_rz           = {1'b0, ra[MSB:1]};
						nxt_flags[CCR_C] = ra[0];
					end
					`ALU_OPC_ASR: begin
						nxt_rz           = {ra[MSB], ra[MSB:1]};
						nxt_flags[CCR_C] = ra[0];
					end
					`ALU_OPC_LSL: begin
						nxt_rz           = {ra[MSB-1:0], 1'b0};
						nxt_flags[CCR_C] = ra[MSB];
					end
					`ALU_OPC_ROR: begin
						nxt_rz           = {exp_flags[CCR_C], ra[MSB:1]};
						nxt_flags[CCR_C] = ra[0];
					end
					`ALU_OPC_ROL: begin
						nxt_rz           = {ra[MSB-1:0], exp_flags[CCR_C]};
						nxt_flags[CCR_C] = ra[MSB];
					end
					`ALU_OPC_MOVE: nxt_rz = ra;
					default: begin
						nxt_rz             = `ALU_ERR_FMT_A;
						nxt_flags[CCR_INR] = 1'b1;
					end
				endcase
			end
			2'd1: begin
				if (opc == `ALU_OPC_NOP) nxt_hold = 1'b1;
				else begin
					nxt_rz             = `ALU_ERR_FMT_B;
					nxt_flags[CCR_INR] = 1'b1;
				end
			end
			2'd2: begin
				if (opc == `ALU_OPC_NOP) nxt_hold = 1'b1;
				else if (opc == `ALU_OPC_LDI)
					nxt_rz = {{(`ALU_DATA_W-`ALU_IMM_C_W){imm[`ALU_IMM_C_W-1]}}, imm};
				else if (opc == `ALU_OPC_LDUI)
					nxt_rz = {{(`ALU_DATA_W-`ALU_IMM_C_W){1'b0}}, imm};
				else begin
					nxt_rz             = `ALU_ERR_FMT_C;
					nxt_flags[CCR_INR] = 1'b1;
				end
			end
			default: begin
				nxt_rz              = `ALU_ERR_FORMAT;
				nxt_flags[CCR_IFNR] = 1'b1;
			end
		endcase
		nxt_flags[CCR_Z] = (nxt_rz == 32'd0);
		nxt_flags[CCR_N] = nxt_rz[MSB];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			exp_rz    <= '0;
			exp_flags <= '0;
			exp_valid <= 1'b0;
		end else begin
			exp_valid <= enable;
			if (enable && !nxt_hold) begin
				exp_rz    <= nxt_rz;
				exp_flags <= nxt_flags;
			end
		end
	end

	assign exp_ccr = {{(`ALU_DATA_W-`ALU_FLAG_W){1'b0}}, exp_flags};

	a_reset_state: assert property (@(posedge clock)
		!rst_n |-> (rz == '0 && ccr == '0 && !result_valid))
		else begin
			reset_errors++;
			$error("ERR %0t reset rz %h ccr %h result_valid %b expected zero",
				$time, rz, ccr, result_valid);
		end

	a_rz: assert property (@(posedge clock) disable iff (!rst_n) rz == exp_rz)
		else begin
			rz_errors++;
			$error("ERR %0t rz got %h expected %h", $time, rz, exp_rz);
		end

	a_ccr: assert property (@(posedge clock) disable iff (!rst_n) ccr == exp_ccr)
		else begin
			ccr_errors++;
			$error("ERR %0t ccr got %h expected %h", $time, ccr, exp_ccr);
		end

	a_valid: assert property (@(posedge clock) disable iff (!rst_n) result_valid == exp_valid)
		else begin
			valid_errors++;
			$error("ERR %0t result_valid got %b expected %b", $time, result_valid, exp_valid);
		end

endmodule

`default_nettype wire

/* tb/alu_core_tb.sv */
// ========================================
// ALU testbench. Directed and LCG random
// instructions; the bound checker judges
// ========================================
`include "alu_params.svh"
`default_nettype none

module alu_core_tb import alu_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES    = 16;
	localparam int DIRECTED_CYCLES = 40;  // Directed list plus tail
	localparam int RANDOM_COUNT    = 300; // One cycle each
	localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_COUNT);
	localparam logic [`ALU_OPC_A_W-1:0] A_OPCODES [13] = '{
		`ALU_OPC_ADD, `ALU_OPC_SUB, `ALU_OPC_AND, `ALU_OPC_OR, `ALU_OPC_NEG,
		`ALU_OPC_XOR, `ALU_OPC_COMP, `ALU_OPC_LSR, `ALU_OPC_ASR, `ALU_OPC_LSL,
		`ALU_OPC_ROR, `ALU_OPC_ROL, `ALU_OPC_MOVE};

	logic                   clock = 1'b0;
	logic                   rst_n;
	logic                   enable;
	logic [1:0]             format;
	logic [`ALU_DATA_W-1:0] instruction;
	logic [`ALU_DATA_W-1:0] ra;
	logic [`ALU_DATA_W-1:0] rb;
	logic [`ALU_DATA_W-1:0] rz;
	logic [`ALU_DATA_W-1:0] ccr;
	logic                   result_valid;
	logic [31:0]            rnd_state = 32'hec92_8f17;
	int                     issued = 0;
	int                     cycle_count = 0;
	int                     errors = 0;

	always #20 clock = ~clock;

	alu_core i_dut (.*);

	bind alu_core alu_core_assertions i_checks (
		.clock        (clock),
		.rst_n        (rst_n),
		.enable       (enable),
		.format       (format),
		.instruction  (instruction),
		.ra           (ra),
		.rb           (rb),
		.rz           (rz),
		.ccr          (ccr),
		.result_valid (result_valid)
	);

	function logic [31:0] random_word(); // LCG step
		rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
		return rnd_state;
	endfunction

	function automatic logic [31:0] word_a(input logic [`ALU_OPC_A_W-1:0] opc);
		return {15'h2b5e, opc}; // Register fields, never decoded
	endfunction

	function automatic logic [31:0] word_b(input logic [`ALU_OPC_W-1:0] opc);
		return {26'h2a5_5a5a, opc};
	endfunction

	function automatic logic [31:0] word_c(input logic [25:0] imm, input logic [5:0] opc);
		return {imm, opc};
	endfunction

	task automatic issue(input logic [1:0] fmt, input logic [31:0] instr,
			input logic [31:0] a, input logic [31:0] b);
		@(posedge clock);
		#2;
		enable      = 1'b1;
		format      = fmt;
		instruction = instr;
		ra          = a;
		rb          = b;
		issued++;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			#2;
			enable      = 1'b0;
			instruction = random_word(); // Junk that must be ignored
			ra          = random_word();
			format      = ra[1:0];
		end
	endtask

	task automatic random_run(input int count);
		logic [31:0] pick;
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < count; i++) begin
			pick = random_word();
			a    = random_word();
			b    = random_word();
			if (pick[3:0] == 4'd0) a = 32'h7FFF_FFFF; // Edge operands now and then
			if (pick[7:4] == 4'd0) b = 32'h8000_0000;
			if (pick[10:8] == 3'd0) idle(1);
			else if (pick[13:11] < 3'd5)
				issue(FMT_A, word_a(pick[19:16] < 4'd13 ? A_OPCODES[pick[19:16]] : b[16:0]), a, b);
			else if (pick[13:11] == 3'd5)
				issue(FMT_B, word_b(pick[21] ? `ALU_OPC_NOP : pick[27:22]), a, b);
			else if (pick[13:11] == 3'd6)
				issue(FMT_C, word_c(a[25:0], pick[23:22] == 2'd0 ? `ALU_OPC_NOP :
					pick[23:22] == 2'd1 ? `ALU_OPC_LDI :
					pick[23:22] == 2'd2 ? `ALU_OPC_LDUI : pick[29:24]), a, b);
			else issue(FMT_BAD, a, a, b);
		end
	endtask

	initial begin
		rst_n       = 1'b1;
		enable      = 1'b0;
		format      = 2'd0;
		instruction = '0;
		ra          = '0;
		rb          = '0;
		#5 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 rst_n = 1'b1;
		idle(3); // No result_valid before the first enable
		issue(FMT_A, word_a(`ALU_OPC_ADD), 32'h7FFF_FFFF, 32'h1); // Positive overflow
		issue(FMT_A, word_a(`ALU_OPC_ADD), 32'hFFFF_FFFF, 32'h1); // Wraps to zero
		issue(FMT_A, word_a(`ALU_OPC_ADD), 32'h8000_0000, 32'h8000_0000);
		issue(FMT_A, word_a(`ALU_OPC_SUB), 32'h8000_0000, 32'h1);
		issue(FMT_A, word_a(`ALU_OPC_SUB), 32'h1234_5678, 32'h1234_5678);
		issue(FMT_A, word_a(`ALU_OPC_SUB), 32'h3, 32'h5);
		issue(FMT_A, word_a(`ALU_OPC_LSL), 32'h8000_0000, 32'h0); // C set for the logic group
		issue(FMT_A, word_a(`ALU_OPC_AND), 32'hF0F0_00FF, 32'h0FF0_FF00);
		issue(FMT_A, word_a(`ALU_OPC_OR), 32'hF000_0001, 32'h0000_F000);
		issue(FMT_A, word_a(`ALU_OPC_XOR), 32'hAAAA_5555, 32'hFFFF_0000);
		issue(FMT_A, word_a(`ALU_OPC_NEG), 32'h1, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_COMP), 32'h0F0F_1234, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_MOVE), 32'h0, 32'hFFFF_FFFF);
		issue(FMT_A, word_a(`ALU_OPC_LSR), 32'h1, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ASR), 32'h8000_0001, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_LSL), 32'h4000_0000, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ROR), 32'h3, 32'h0); // Back to back rotates
		issue(FMT_A, word_a(`ALU_OPC_ROR), 32'h0, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ROR), 32'h0, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ROL), 32'h8000_0000, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ROL), 32'h0, 32'h0);
		issue(FMT_A, word_a(`ALU_OPC_ROL), 32'h0, 32'h0);
		issue(FMT_C, word_c(26'h200_0001, `ALU_OPC_LDI), 32'h0, 32'h0);
		issue(FMT_C, word_c(26'h0AB_CDEF, `ALU_OPC_LDI), 32'h0, 32'h0);
		issue(FMT_C, word_c(26'h3FF_FFFF, `ALU_OPC_LDUI), 32'h0, 32'h0);
		issue(FMT_B, word_b(`ALU_OPC_NOP), 32'h1, 32'h1);
		issue(FMT_C, word_c(26'h0, `ALU_OPC_NOP), 32'h1, 32'h1);
		idle(2);
		issue(FMT_A, word_a(17'h1_FFFF), 32'h5, 32'h6); // Unknown format a opcode
		issue(FMT_A, word_a(`ALU_OPC_MOVE), 32'h5, 32'h0);
		issue(FMT_B, word_b(6'h00), 32'h5, 32'h6);
		issue(FMT_C, word_c(26'h0, 6'h00), 32'h5, 32'h6);
		issue(FMT_BAD, 32'h0, 32'h5, 32'h6);
		issue(FMT_A, word_a(`ALU_OPC_MOVE), 32'h7, 32'h0); // Clears INR and IFNR
		random_run(RANDOM_COUNT);
		idle(2);
		errors += i_dut.i_checks.rz_errors + i_dut.i_checks.ccr_errors
			+ i_dut.i_checks.valid_errors + i_dut.i_checks.reset_errors;
		$display("Issued %0d, errors rz %0d ccr %0d result_valid %0d reset %0d total %0d",
			issued, i_dut.i_checks.rz_errors, i_dut.i_checks.ccr_errors,
			i_dut.i_checks.valid_errors, i_dut.i_checks.reset_errors, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout, stimulus still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
